// File: Bender.yml
package:
  name: digit_row_display

sources:
  - include_dirs:
      - hw
    files:
      - hw/defines.sv
      - hw/vgaScanner.sv
      - hw/square.sv
      - hw/numberBitmap.sv
      - hw/Obstacle.sv
      - hw/displayTop.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/clockGen.sv
      - verification/displayTopTb.sv

// File: hw/Obstacle.sv
`timescale 1ns/1ns

`include "display_consts.svh"

module Obstacle (
	input  logic            clk,
	input  logic            reset,
	input  defines::coord_t pixelX,
	input  defines::coord_t pixelY,
	input  defines::digit_t scoreNumber,
	output logic            drawObstacle,
	output defines::rgb_t   RGBObstacle,
	output logic            drawScoreNumber
);

	import defines::*;

	logic [`NUMBERS-1:0] drawSquare;
	offset_t             offsetXSquare [`NUMBERS];
	offset_t             offsetYSquare [`NUMBERS];

	digit_t  numberToDraw;
	digit_t  numberToDrawD;
	offset_t offsetXNumber;
	offset_t offsetYNumber;
	logic    insideRectangle;
	logic    drawNumber;
	rgb_t    RGBNumber;

	// ============================================================
	// Tile row
	// ============================================================

	for (genvar i = 0; i < `NUMBERS; i++) begin : squareTiles
		square #(
			.OBJECT_WIDTH (`NUMBER_WIDTH),
			.OBJECT_HEIGHT(`NUMBER_HEIGHT),
			.TOP_LEFT_X   (`ROW_LEFT_X + i * `NUMBERS_SPACE),
			.TOP_LEFT_Y   (`ROW_TOP_Y)
		) squareInst (
			.pixelX (pixelX),
			.pixelY (pixelY),
			.draw   (drawSquare[i]),
			.offsetX(offsetXSquare[i]),
			.offsetY(offsetYSquare[i])
		);
	end

	// Highest index wins.
	always_comb begin
		numberToDraw  = '0;
		offsetXNumber = offsetXSquare[0];
		offsetYNumber = offsetYSquare[0];
		for (int j = 1; j < `NUMBERS; j++) begin
			if (drawSquare[j]) begin
				numberToDraw  = digit_t'(j);
				offsetXNumber = offsetXSquare[j];
				offsetYNumber = offsetYSquare[j];
			end
		end
	end

	assign insideRectangle = |drawSquare;

	numberBitmap numberBitmapInst (
		.clk            (clk),
		.reset          (reset),
		.offsetX        (offsetXNumber),
		.offsetY        (offsetYNumber),
		.number         (numberToDraw),
		.insideRectangle(insideRectangle),
		.drawNumber     (drawNumber),
		.RGBNumber      (RGBNumber)
	);

	// ============================================================
	// Score match, aligned with the bitmap register
	// ============================================================

	always_ff @(posedge clk) begin
		numberToDrawD <= numberToDraw;
	end

	assign drawObstacle    = drawNumber;
	assign RGBObstacle     = RGBNumber;
	assign drawScoreNumber = drawNumber && (numberToDrawD == scoreNumber);

	// Tiles are spaced apart, so hits never overlap.
	singleTileHit: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0(drawSquare)
	) else $error("Obstacle: overlapping tile hits %b", drawSquare);

endmodule

// File: hw/defines.sv
// ============================================================
// Shared types of the digit-row display.
// ============================================================

package defines;

	// Screen position as produced by the raster scanner.
	// Signed so that tile bounds can be compared without casts.
	typedef logic signed [10:0] coord_t;

	// Position of a pixel relative to the top-left corner of a tile.
	typedef logic [10:0] offset_t;

	// Decimal digit shown by a tile, 0 to 9.
	typedef logic [3:0] digit_t;

	// Colour in 3-3-2 RGB.
	// Bits 7:5 red, 4:2 green, 1:0 blue.
	typedef logic [7:0] rgb_t;

endpackage

// File: hw/displayTop.sv
`timescale 1ns/1ns

`include "display_consts.svh"

module displayTop (
	input  logic            clk,
	input  logic            reset,
	input  defines::digit_t scoreNumber,
	output defines::rgb_t   rgb,
	output logic            hSync,
	output logic            vSync,
	output logic            scoreHit
);

	import defines::*;

	coord_t pixelX;
	coord_t pixelY;
	logic   visible;
	logic   hSyncRaw;
	logic   vSyncRaw;

	logic   drawObstacle;
	rgb_t   RGBObstacle;
	logic   drawScoreNumber;

	logic   visibleD;
	logic   hSyncD;
	logic   vSyncD;
	rgb_t   nextRgb;

	vgaScanner vgaScannerInst (
		.clk     (clk),
		.reset   (reset),
		.pixelX  (pixelX),
		.pixelY  (pixelY),
		.visible (visible),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw)
	);

	Obstacle obstacleInst (
		.clk            (clk),
		.reset          (reset),
		.pixelX         (pixelX),
		.pixelY         (pixelY),
		.scoreNumber    (scoreNumber),
		.drawObstacle   (drawObstacle),
		.RGBObstacle    (RGBObstacle),
		.drawScoreNumber(drawScoreNumber)
	);

	// ============================================================
	// Stage 1, raster flags follow the bitmap latency
	// ============================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			visibleD <= 1'b0;
			hSyncD   <= 1'b1;
			vSyncD   <= 1'b1;
		end else begin
			visibleD <= visible;
			hSyncD   <= hSyncRaw;
			vSyncD   <= vSyncRaw;
		end
	end

	// Colour priority: blanking, score digit, plain digit, background.
	always_comb begin
		if (!visibleD) begin
			nextRgb = `COLOR_BLANK;
		end else if (drawScoreNumber) begin
			nextRgb = `COLOR_SCORE;
		end else if (drawObstacle) begin
			nextRgb = RGBObstacle;
		end else begin
			nextRgb = `COLOR_BACKGROUND;
		end
	end

	// ============================================================
	// Stage 2, output registers
	// ============================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			rgb      <= '0;
			hSync    <= 1'b1;
			vSync    <= 1'b1;
			scoreHit <= 1'b0;
		end else begin
			rgb      <= nextRgb;
			hSync    <= hSyncD;
			vSync    <= vSyncD;
			scoreHit <= drawScoreNumber;
		end
	end

endmodule

// File: hw/display_consts.svh
`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

// 640x480 raster timing, counted in pixel clocks.
`define H_VISIBLE 640
`define H_SYNC_START 656
`define H_SYNC_END 752
`define H_TOTAL 800
`define V_VISIBLE 480
`define V_SYNC_START 490
`define V_SYNC_END 492
`define V_TOTAL 525

// Digit tile geometry.
`define NUMBER_WIDTH 16
`define NUMBER_HEIGHT 32
`define NUMBERS 10
`define NUMBERS_SPACE 40
`define ROW_LEFT_X 20
`define ROW_TOP_Y 60

// Palette.
`define COLOR_DIGIT 8'hFF
`define COLOR_SCORE 8'hE0
`define COLOR_BACKGROUND 8'h25
`define COLOR_BLANK 8'h00

`endif

// File: hw/numberBitmap.sv
`timescale 1ns/1ns

`include "display_consts.svh"

module numberBitmap (
	input  logic             clk,
	input  logic             reset,
	input  defines::offset_t offsetX,
	input  defines::offset_t offsetY,
	input  defines::digit_t  number,
	input  logic             insideRectangle,
	output logic             drawNumber,
	output defines::rgb_t    RGBNumber
);

	import defines::*;

	// Segment order in the vectors below is {a, b, c, d, e, f, g}.
	logic [6:0] segmentsOn;
	logic [6:0] segmentsHit;
	logic       lit;

	// Inclusive box test on tile-relative coordinates.
	function automatic logic inBox(
		input offset_t x,
		input offset_t y,
		input int      x0,
		input int      x1,
		input int      y0,
		input int      y1
	);
		return (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);
	endfunction

	// ============================================================
	// Digit to segment decode
	// ============================================================

	always_comb begin
		case (number)
			4'd0:    segmentsOn = 7'b1111110;
			4'd1:    segmentsOn = 7'b0110000;
			4'd2:    segmentsOn = 7'b1101101;
			4'd3:    segmentsOn = 7'b1111001;
			4'd4:    segmentsOn = 7'b0110011;
			4'd5:    segmentsOn = 7'b1011011;
			4'd6:    segmentsOn = 7'b1011111;
			4'd7:    segmentsOn = 7'b1110000;
			4'd8:    segmentsOn = 7'b1111111;
			4'd9:    segmentsOn = 7'b1111011;
			default: segmentsOn = 7'b0000000;
		endcase
	end

	// ============================================================
	// Segment geometry for a 16x32 tile
	// ============================================================

	// Horizontal bars span columns 2 to 13, four rows thick.
	assign segmentsHit[6] = inBox(offsetX, offsetY, 2, 13, 0, 3);
	assign segmentsHit[0] = inBox(offsetX, offsetY, 2, 13, 14, 17);
	assign segmentsHit[3] = inBox(offsetX, offsetY, 2, 13, 28, 31);

	// Vertical bars, upper half.
	assign segmentsHit[1] = inBox(offsetX, offsetY, 0, 3, 2, 15);
	assign segmentsHit[5] = inBox(offsetX, offsetY, 12, 15, 2, 15);

	// Vertical bars, lower half.
	assign segmentsHit[2] = inBox(offsetX, offsetY, 0, 3, 16, 29);
	assign segmentsHit[4] = inBox(offsetX, offsetY, 12, 15, 16, 29);

	assign lit = insideRectangle && |(segmentsOn & segmentsHit);

	// One pipeline stage between offsets and pixel decision.
	always_ff @(posedge clk) begin
		if (reset) begin
			drawNumber <= 1'b0;
		end else begin
			drawNumber <= lit;
		end
	end

	always_ff @(posedge clk) begin
		RGBNumber <= lit ? rgb_t'(`COLOR_DIGIT) : rgb_t'(`COLOR_BACKGROUND);
	end

	// The digit comes from the tile selector in the parent.
	digitInRange: assert property (
		@(posedge clk) disable iff (reset)
		insideRectangle |-> (number <= 4'd9)
	) else $error("numberBitmap: digit %0d out of range", number);

endmodule

// File: hw/square.sv
`timescale 1ns/1ns

module square #(
	parameter int OBJECT_WIDTH  = 16,
	parameter int OBJECT_HEIGHT = 32,
	parameter int TOP_LEFT_X    = 0,
	parameter int TOP_LEFT_Y    = 0
) (
	input  defines::coord_t  pixelX,
	input  defines::coord_t  pixelY,
	output logic             draw,
	output defines::offset_t offsetX,
	output defines::offset_t offsetY
);

	import defines::*;

	// Tile bounds, right and bottom are exclusive.
	localparam coord_t LEFT   = coord_t'(TOP_LEFT_X);
	localparam coord_t TOP    = coord_t'(TOP_LEFT_Y);
	localparam coord_t RIGHT  = coord_t'(TOP_LEFT_X + OBJECT_WIDTH);
	localparam coord_t BOTTOM = coord_t'(TOP_LEFT_Y + OBJECT_HEIGHT);

	logic insideX;
	logic insideY;

	assign insideX = (pixelX >= LEFT) && (pixelX < RIGHT);
	assign insideY = (pixelY >= TOP) && (pixelY < BOTTOM);

	assign draw = insideX && insideY;

	// Only meaningful while draw is high.
	assign offsetX = offset_t'(pixelX - LEFT);
	assign offsetY = offset_t'(pixelY - TOP);

endmodule

// File: hw/vgaScanner.sv
`timescale 1ns/1ns

`include "display_consts.svh"

module vgaScanner (
	input  logic            clk,
	input  logic            reset,
	output defines::coord_t pixelX,
	output defines::coord_t pixelY,
	output logic            visible,
	output logic            hSyncRaw,
	output logic            vSyncRaw
);

	import defines::*;

	coord_t hCount;
	coord_t vCount;
	logic   lineEnd;
	logic   frameEnd;

	// ============================================================
	// Raster counters
	// ============================================================

	assign lineEnd  = (hCount == coord_t'(`H_TOTAL - 1));
	assign frameEnd = (vCount == coord_t'(`V_TOTAL - 1));

	// Column counter, one step per pixel clock.
	always_ff @(posedge clk) begin
		if (reset) begin
			hCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
		end else begin
			hCount <= hCount + coord_t'(1);
		end
	end

	// Row counter advances at the end of each line.
	always_ff @(posedge clk) begin
		if (reset) begin
			vCount <= '0;
		end else if (lineEnd) begin
			if (frameEnd) begin
				vCount <= '0;
			end else begin
				vCount <= vCount + coord_t'(1);
			end
		end
	end

	assign pixelX = hCount;
	assign pixelY = vCount;

	// ============================================================
	// Blanking and sync levels
	// ============================================================

	assign visible = (hCount < `H_VISIBLE) && (vCount < `V_VISIBLE);

	// Both sync pulses are active low.
	assign hSyncRaw = !((hCount >= `H_SYNC_START) && (hCount < `H_SYNC_END));
	assign vSyncRaw = !((vCount >= `V_SYNC_START) && (vCount < `V_SYNC_END));

	columnInRange: assert property (
		@(posedge clk) disable iff (reset)
		hCount < coord_t'(`H_TOTAL)
	) else $error("vgaScanner: column count left the line");

endmodule

// File: src.f
+incdir+hw
hw/defines.sv
hw/vgaScanner.sv
hw/square.sv
hw/numberBitmap.sv
hw/Obstacle.sv
hw/displayTop.sv
verification/clockGen.sv
verification/displayTopTb.sv

// File: verification/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset is released just after the last reset edge.
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// File: verification/displayTopTb.sv
`timescale 1ns/1ns

`include "display_consts.svh"

module displayTopTb;

	import defines::*;

	localparam int CLK_PERIOD   = 20;
	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int TIMEOUT_NS   = 2 * FRAME_CYCLES * CLK_PERIOD;
	localparam int PIPE_DELAY   = 2;
	localparam int MAX_ENTRIES  = 32;

	logic   clk;
	logic   reset;
	digit_t scoreNumber;
	rgb_t   rgb;
	logic   hSync;
	logic   vSync;
	logic   scoreHit;

	int cycleCount;

	string entryName  [MAX_ENTRIES];
	int    entryScore [MAX_ENTRIES];
	int    entryCol   [MAX_ENTRIES];
	int    entryRow   [MAX_ENTRIES];
	int    entryRgb   [MAX_ENTRIES];
	int    entryHit   [MAX_ENTRIES];
	int    entryHSync [MAX_ENTRIES];
	int    entryCount;

	clockGen #(
		.PERIOD      (CLK_PERIOD),
		.RESET_CYCLES(3)
	) clockGenInst (
		.clk  (clk),
		.reset(reset)
	);

	displayTop displayTop_inst (
		.clk        (clk),
		.reset      (reset),
		.scoreNumber(scoreNumber),
		.rgb        (rgb),
		.hSync      (hSync),
		.vSync      (vSync),
		.scoreHit   (scoreHit)
	);

	// Cycles since reset release, pixel k reaches the outputs at k + 2.
	always @(posedge clk) begin
		if (reset) begin
			cycleCount <= 0;
		end else begin
			cycleCount <= cycleCount + 1;
		end
	end

	// ============================================================
	// Helpers
	// ============================================================

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			$display("Checks failed");
			$fatal(1, "Stopped at the first mismatch.");
		end
	endtask

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "Run aborted.");
	endtask

	task automatic addEntry(input string name, input int score, input int col, input int row,
		input int rgbValue, input int hit, input int hs);
		entryName[entryCount]  = name;
		entryScore[entryCount] = score;
		entryCol[entryCount]   = col;
		entryRow[entryCount]   = row;
		entryRgb[entryCount]   = rgbValue;
		entryHit[entryCount]   = hit;
		entryHSync[entryCount] = hs;
		entryCount++;
	endtask

	// New score must be in place before the pixel reaches the score compare.
	task automatic applyScore(input int score, input int col, input int row);
		int target;
		target = row * `H_TOTAL + col + PIPE_DELAY;
		if (target < cycleCount + 2) begin
			stopRun($sformatf("Score change for pixel (%0d,%0d) comes too late", col, row));
		end
		@(posedge clk);
		scoreNumber <= digit_t'(score);
	endtask

	// Returns at the falling edge where the pixel's outputs are stable.
	task automatic waitForPixel(input int col, input int row);
		int target;
		target = row * `H_TOTAL + col + PIPE_DELAY;
		if (target <= cycleCount) begin
			stopRun($sformatf("Pixel (%0d,%0d) already passed the outputs", col, row));
		end
		do begin
			@(negedge clk);
		end while (cycleCount < target);
	endtask

	function automatic logic inSegment(input byte name, input int c, input int r);
		case (name)
			"a": return (c >= 2) && (c <= 13) && (r >= 0) && (r <= 3);
			"g": return (c >= 2) && (c <= 13) && (r >= 14) && (r <= 17);
			"d": return (c >= 2) && (c <= 13) && (r >= 28) && (r <= 31);
			"f": return (c >= 0) && (c <= 3) && (r >= 2) && (r <= 15);
			"b": return (c >= 12) && (c <= 15) && (r >= 2) && (r <= 15);
			"e": return (c >= 0) && (c <= 3) && (r >= 16) && (r <= 29);
			"c": return (c >= 12) && (c <= 15) && (r >= 16) && (r <= 29);
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic segmentLit(input int digit, input int c, input int r);
		string segs;
		logic  lit;
		lit = 1'b0;
		case (digit)
			0: segs = "abcdef";
			1: segs = "bc";
			2: segs = "abdeg";
			3: segs = "abcdg";
			4: segs = "bcfg";
			5: segs = "acdfg";
			6: segs = "acdefg";
			7: segs = "abc";
			8: segs = "abcdefg";
			9: segs = "abcdfg";
			default: segs = "";
		endcase
		for (int i = 0; i < segs.len(); i++) begin
			if (inSegment(segs[i], c, r)) begin
				lit = 1'b1;
			end
		end
		return lit;
	endfunction

	// Reference colour of one pixel.
	task automatic expectPixel(input int col, input int row, input int score,
		output logic [7:0] colour, output logic hit, output logic hs);
		int   tile;
		int   c;
		int   r;
		logic lit;
		tile = -1;
		lit  = 1'b0;
		hit  = 1'b0;
		hs   = !((col >= `H_SYNC_START) && (col < `H_SYNC_END));
		if ((col >= `H_VISIBLE) || (row >= `V_VISIBLE)) begin
			colour = `COLOR_BLANK;
		end else begin
			if ((row >= `ROW_TOP_Y) && (row < `ROW_TOP_Y + `NUMBER_HEIGHT) &&
				(col >= `ROW_LEFT_X)) begin
				tile = (col - `ROW_LEFT_X) / `NUMBERS_SPACE;
				c    = (col - `ROW_LEFT_X) % `NUMBERS_SPACE;
				r    = row - `ROW_TOP_Y;
				if ((tile < `NUMBERS) && (c < `NUMBER_WIDTH)) begin
					lit = segmentLit(tile, c, r);
				end
			end
			if (lit && (tile == score)) begin
				colour = `COLOR_SCORE;
				hit    = 1'b1;
			end else if (lit) begin
				colour = `COLOR_DIGIT;
			end else begin
				colour = `COLOR_BACKGROUND;
			end
		end
	endtask

	// ============================================================
	// Check table, in raster order
	// ============================================================

	task automatic buildTable();
		addEntry("background row 10", 0, 5, 10, `COLOR_BACKGROUND, 0, 1);
		addEntry("last visible column", 0, 639, 10, `COLOR_BACKGROUND, 0, 1);
		addEntry("first blank column", 0, 640, 10, `COLOR_BLANK, 0, 1);
		addEntry("column before hsync", 0, 655, 10, `COLOR_BLANK, 0, 1);
		addEntry("first hsync column", 0, 656, 10, `COLOR_BLANK, 0, 0);
		addEntry("last hsync column", 0, 751, 10, `COLOR_BLANK, 0, 0);
		addEntry("column after hsync", 0, 752, 10, `COLOR_BLANK, 0, 1);
		addEntry("tile 0 segment a", 3, 25, 61, `COLOR_DIGIT, 0, 1);
		addEntry("tile 1 without a", 3, 65, 61, `COLOR_BACKGROUND, 0, 1);
		addEntry("tile 3 segment a score", 3, 145, 61, `COLOR_SCORE, 1, 1);
		addEntry("tile 1 segment b", 0, 72, 65, `COLOR_DIGIT, 0, 1);
		addEntry("tile 1 segment b score", 1, 72, 66, `COLOR_SCORE, 1, 1);
		addEntry("tile 1 after score moved", 7, 72, 67, `COLOR_DIGIT, 0, 1);
		addEntry("tile 7 segment b score", 7, 312, 67, `COLOR_SCORE, 1, 1);
		addEntry("tile 5 segment f", 7, 220, 70, `COLOR_DIGIT, 0, 1);
		addEntry("tile 5 without b", 7, 233, 70, `COLOR_BACKGROUND, 0, 1);
		addEntry("blank beside tile rows", 7, 700, 70, `COLOR_BLANK, 0, 0);
		addEntry("tile 0 centre unlit", 0, 28, 76, `COLOR_BACKGROUND, 0, 1);
		addEntry("tile 8 segment g", 0, 348, 76, `COLOR_DIGIT, 0, 1);
		addEntry("tile 8 segment g score", 8, 348, 77, `COLOR_SCORE, 1, 1);
		addEntry("gap between tiles 0 and 1", 8, 40, 80, `COLOR_BACKGROUND, 0, 1);
		addEntry("tile 2 segment e", 8, 101, 80, `COLOR_DIGIT, 0, 1);
		addEntry("tile 2 without c", 8, 114, 80, `COLOR_BACKGROUND, 0, 1);
		addEntry("tile 9 without e", 8, 381, 80, `COLOR_BACKGROUND, 0, 1);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		string      name;
		logic [7:0] expRgb;
		logic       expHit;
		logic       expHs;
		int         col;
		int         score;
		int         randomRows [3];
		randomRows  = '{84, 88, 90};
		scoreNumber = '0;
		entryCount  = 0;
		void'($urandom(16054));
		buildTable();

		// Reset and the two cycles after it.
		@(posedge clk);
		@(negedge clk);
		while (reset || (cycleCount < PIPE_DELAY)) begin
			checkValue("reset rgb", `COLOR_BLANK, rgb);
			checkValue("reset hSync", 1, hSync);
			checkValue("reset vSync", 1, vSync);
			checkValue("reset scoreHit", 0, scoreHit);
			@(negedge clk);
		end

		for (int i = 0; i < entryCount; i++) begin
			if (entryScore[i] != int'(scoreNumber)) begin
				applyScore(entryScore[i], entryCol[i], entryRow[i]);
			end
			waitForPixel(entryCol[i], entryRow[i]);
			checkValue($sformatf("%s rgb", entryName[i]), entryRgb[i], rgb);
			checkValue($sformatf("%s scoreHit", entryName[i]), entryHit[i], scoreHit);
			checkValue($sformatf("%s hSync", entryName[i]), entryHSync[i], hSync);
		end

		// Random score and column per tile on the lower segment rows.
		foreach (randomRows[k]) begin
			for (int t = 0; t < `NUMBERS; t++) begin
				col   = `ROW_LEFT_X + t * `NUMBERS_SPACE + ($urandom % `NUMBER_WIDTH);
				score = $urandom % 10;
				expectPixel(col, randomRows[k], score, expRgb, expHit, expHs);
				name = $sformatf("random row %0d tile %0d", randomRows[k], t);
				if (score != int'(scoreNumber)) begin
					applyScore(score, col, randomRows[k]);
				end
				waitForPixel(col, randomRows[k]);
				checkValue($sformatf("%s rgb", name), expRgb, rgb);
				checkValue($sformatf("%s scoreHit", name), expHit, scoreHit);
				checkValue($sformatf("%s hSync", name), expHs, hSync);
			end
		end

		// Vertical sync edges.
		waitForPixel(799, 489);
		checkValue("row 489 vSync", 1, vSync);
		checkValue("row 489 rgb", `COLOR_BLANK, rgb);
		waitForPixel(0, 490);
		checkValue("row 490 vSync", 0, vSync);
		checkValue("row 490 rgb", `COLOR_BLANK, rgb);
		waitForPixel(0, 491);
		checkValue("row 491 vSync", 0, vSync);
		waitForPixel(0, 492);
		checkValue("row 492 vSync", 1, vSync);

		$display("All checks passed");
		$finish;
	end

	// Two full frames are more than the whole sequence needs.
	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the checks finished.");
		$display("Checks failed");
		$fatal(1, "Timeout.");
	end

endmodule
